/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = erx_tb
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/erx_tb_tasks.svh */
// eLink RX testbench tasks
// Frame drivers, packet model and output checks

// One link byte, sampled by the DUT at the next edge
task automatic drive_byte(input logic [7:0] b);
  @(posedge clk);
  frame <= 1'b1;
  data <= b;
endtask

// Frame low for at least one cycle
task automatic end_frame();
  @(posedge clk);
  frame <= 1'b0;
  data <= 8'h00;
endtask

// Expected output packet from the link fields
function automatic logic [PW-1:0] predict_packet(input logic [7:0]    hdr,
                                                 input logic [AW-1:0] dst,
                                                 input logic [DW-1:0] dat,
                                                 input logic [AW-1:0] src);
  logic [AW-1:0] out_dst;
  logic          local_hit;
  out_dst = dst;
  local_hit = (dst[31:20] == CHIP_ID);  // Local traffic skips remap
  if (!local_hit && dst[31:28] == REMAP_SEL) begin
    out_dst[31:28] = REMAP_BASE;
  end
  // srcaddr, data, dstaddr, ctrlmode, datamode, write
  return {src, dat, out_dst, hdr[4:0], hdr[6:5], hdr[7]};
endfunction

// Header group plus n_burst continuation groups
// Groups from enable_at onward are expected at the output
task automatic send_frame(input logic [7:0]    hdr,
                          input logic [AW-1:0] dst,
                          input int            n_burst,
                          input int            enable_at);
  logic [AW-1:0] addr;
  logic [DW-1:0] dat;
  logic [AW-1:0] src;
  logic [95:0]   payload;
  int            n_bytes;
  for (int g = 0; g <= n_burst; g++) begin
    dat = $urandom;
    src = $urandom;
    addr = (g == 0) ? dst : model_dst + BURST_STRIDE;
    model_dst = addr;  // Tracked even while disabled
    payload = {addr, dat, src};
    n_bytes = (g == 0) ? HDR_BYTES - 1 : BURST_BYTES;
    if (g == 0) begin
      drive_byte(hdr);
    end
    for (int i = n_bytes - 1; i >= 0; i--) begin
      drive_byte(payload[8*i +: 8]);  // MSB first
      // Late enough that the previous group still sees it low
      if (g == enable_at && i == n_bytes - 2) begin
        rx_enable <= 1'b1;
      end
    end
    if (g >= enable_at) begin
      exp_pkt_q.push_back(predict_packet(hdr, addr, dat, src));
      exp_time_q.push_back($time + OUT_DELAY);
      n_expected++;
    end
  end
  end_frame();
endtask

// Partial group then frame drop
task automatic send_abort(input int n_bytes);
  for (int i = 0; i < n_bytes; i++) begin
    drive_byte(8'($urandom));
  end
  end_frame();
endtask

// Wait for expected outputs, then a few cycles for strays
task automatic wait_drain();
  for (int i = 0; i < DRAIN_CYCLES && exp_pkt_q.size() != 0; i++) begin
    @(posedge clk);
  end
  repeat (4) @(posedge clk);
  if (exp_pkt_q.size() != 0) begin
    fail_run("expected transactions did not come out");
  end
endtask

task automatic check_value(input string         name,
                           input logic [PW-1:0] expected,
                           input logic [PW-1:0] actual);
  if (actual !== expected) begin
    fail_run($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
  end
endtask

/* dv/erx_tb.sv */
`timescale 1ns/1ns
// eLink RX testbench
// Directed frames through the receive path, checked against a packet model

module erx_tb import erx_pkg::*; ();

  localparam time CLK_PERIOD = 20;
  localparam time OUT_DELAY = CLK_PERIOD * 7 / 2;  // Last byte drive to out_access at negedge
  localparam int RESET_CYCLES = 10;
  localparam int DRAIN_CYCLES = 16;
  localparam int KEEP_DISABLED = 99;  // Group index never reached
  localparam logic [31:0] SEED = 32'h4b6d_d37b;

  // Watchdog budget, worst case frame times every frame sent plus drains
  localparam int MAX_FRAME_CYCLES = HDR_BYTES + 4 * BURST_BYTES + 2;
  localparam int NUM_FRAMES = 16;
  localparam int NUM_DRAINS = 8;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_FRAMES * MAX_FRAME_CYCLES +
                                   NUM_DRAINS * (DRAIN_CYCLES + 4) + 100;

  logic          clk = 1'b0;
  logic          arst_n;
  logic          rx_enable;
  logic          frame;
  logic [7:0]    data;
  logic          out_access;
  logic [PW-1:0] out_packet;

  // Expected transactions in arrival order
  logic [PW-1:0] exp_pkt_q[$];
  time           exp_time_q[$];  // Negedge where out_access is due
  logic [AW-1:0] model_dst;      // Tracked burst address
  int            n_expected;
  int            n_seen;

  // Report and stop
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  `include "erx_tb_tasks.svh"

  erx_top i_erx_top (
    .clk        (clk),
    .arst_n     (arst_n),
    .rx_enable  (rx_enable),
    .frame      (frame),
    .data       (data),
    .out_access (out_access),
    .out_packet (out_packet)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Output monitor, sampled mid cycle
  always @(negedge clk) begin
    if (out_access === 1'b1) begin
      if (exp_pkt_q.size() == 0) begin
        fail_run("out_access pulse with no transaction expected");
      end else begin
        check_value("out_packet", exp_pkt_q.pop_front(), out_packet);
        check_value("out_access time", PW'(exp_time_q.pop_front()), PW'($time));
        n_seen++;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_run("watchdog timeout, test sequence did not finish");
  end

  task automatic test_single();
    logic [AW-1:0] dst;
    dst = $urandom;
    if (dst[31:28] == REMAP_SEL) begin
      dst[31:28] = ~REMAP_SEL;  // Keep out of the remap region
    end
    send_frame(8'($urandom), dst, 0, 0);
    wait_drain();
  endtask

  task automatic test_burst();
    send_frame(8'($urandom), $urandom, 4, 0);  // Header plus 4 continuation groups
    wait_drain();
  endtask

  task automatic test_remap();
    logic [AW-1:0] dst;
    dst = {REMAP_SEL, 28'($urandom)};
    if (dst[31:20] == CHIP_ID) begin
      dst[27] = ~dst[27];  // Remote address in the remap region
    end
    send_frame(8'($urandom), dst, 1, 0);
    // Local chip address in the same region must pass unchanged
    send_frame(8'($urandom), {CHIP_ID, 20'($urandom)}, 1, 0);
    wait_drain();
  endtask

  task automatic test_enable();
    @(posedge clk);
    rx_enable <= 1'b0;
    send_frame(8'($urandom), $urandom, 1, KEEP_DISABLED);  // Nothing may leave
    wait_drain();
    // Enable rises in the third group, addresses keep counting
    send_frame(8'($urandom), $urandom, 3, 2);
    wait_drain();
  endtask

  task automatic test_abort();
    send_abort(1);              // Header byte only
    send_abort(7);              // Inside dstaddr/data
    send_abort(HDR_BYTES - 1);  // One byte short
    send_frame(8'($urandom), $urandom, 1, 0);
    wait_drain();
  endtask

  task automatic test_back_to_back();
    for (int f = 0; f < 6; f++) begin
      send_frame(8'($urandom), $urandom, int'($urandom_range(2, 0)), 0);
    end
    wait_drain();
  endtask

  initial begin
    void'($urandom(SEED));
    arst_n <= 1'b0;
    rx_enable <= 1'b0;
    frame <= 1'b0;
    data <= 8'h00;
    model_dst = '0;
    n_expected = 0;
    n_seen = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    rx_enable <= 1'b1;
    repeat (2) @(posedge clk);
    test_single();
    test_burst();
    test_remap();
    test_enable();
    test_abort();
    test_back_to_back();
    if (n_seen != n_expected || exp_pkt_q.size() != 0) begin
      fail_run("transaction count differs at end of run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

/* source/erx_deser.sv */
`timescale 1ns/1ns
// eLink RX frame deserializer
// Collects framed bytes into raw transactions, one header group then bursts

module erx_deser import erx_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          frame,      // High for the whole frame
  input  logic [7:0]    data,       // One byte per clk
  output logic          rx_access,  // Group complete, one cycle
  output logic          rx_burst,   // Continuation group
  output logic [PW-1:0] rx_packet
);

  deser_state_t state;
  logic [3:0] byte_cnt;  // Payload bytes taken in current group
  logic [7:0] hdr_byte;  // Saved for burst groups
  logic [SHIFT_W-1:0] shift_q;
  logic [SHIFT_W-1:0] shift_next;
  logic last_hdr;
  logic last_burst;
  logic [PW-1:0] pkt;

  // MSB first per field, newest byte at the bottom
  assign shift_next = {shift_q[SHIFT_W-9:0], data};

  // Byte sampled this edge closes a group
  assign last_hdr = frame && (state == HEADER) &&
                    (byte_cnt == 4'(HDR_BYTES - 2));
  assign last_burst = frame && (state == BURST) &&
                      (byte_cnt == 4'(BURST_BYTES - 1));

  // Map shifted bytes into packet fields
  always_comb begin
    pkt = '0;
    pkt[WRITE_BIT] = hdr_byte[HDR_WRITE_BIT];
    pkt[DMODE_LSB +: DMODE_W] = hdr_byte[HDR_DMODE_LSB +: DMODE_W];
    pkt[CTRL_LSB +: CTRL_W] = hdr_byte[HDR_CTRL_LSB +: CTRL_W];
    // Burst groups carry no address
    if (state == HEADER) begin
      pkt[DST_LSB +: AW] = shift_next[AW+DW +: AW];
    end
    pkt[DATA_LSB +: DW] = shift_next[AW +: DW];
    pkt[SRC_LSB +: AW] = shift_next[0 +: AW];
  end

  // Control FSM
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      byte_cnt <= '0;
      rx_access <= 1'b0;
      rx_burst <= 1'b0;
    end else begin
      rx_access <= last_hdr || last_burst;
      rx_burst <= last_burst;
      if (!frame) begin
        // Frame end, partial group is dropped
        state <= IDLE;
        byte_cnt <= '0;
      end else begin
        case (state)
          IDLE: begin
            state <= HEADER;  // This byte is the header byte
            byte_cnt <= '0;
          end
          HEADER: begin
            if (last_hdr) begin
              state <= BURST;
              byte_cnt <= '0;
            end else begin
              byte_cnt <= byte_cnt + 4'd1;
            end
          end
          BURST: begin
            if (last_burst) begin
              byte_cnt <= '0;  // Next continuation group
            end else begin
              byte_cnt <= byte_cnt + 4'd1;
            end
          end
          default: state <= IDLE;
        endcase
      end
    end
  end

  // Byte capture and packet output
  always_ff @(posedge clk) begin
    if (frame) begin
      shift_q <= shift_next;
    end
    if (frame && state == IDLE) begin
      hdr_byte <= data;
    end
    if (last_hdr || last_burst) begin
      rx_packet <= pkt;
    end
  end

  // One group per pulse, groups are many bytes apart
  a_access_single: assert property (
    @(posedge clk) disable iff (!arst_n) rx_access |=> !rx_access
  );

  // Burst flag qualifies a pulse only
  a_burst_with_access: assert property (
    @(posedge clk) disable iff (!arst_n) rx_burst |-> rx_access
  );

endmodule

/* source/erx_pkg.sv */
// eLink RX shared definitions
// Packet layout, link framing constants and the deserializer state type

package erx_pkg;

  // Transaction widths
  localparam int AW = 32;
  localparam int DW = 32;
  localparam int PW = 104;

  // Field positions in the 104-bit packet
  localparam int WRITE_BIT = 0;
  localparam int DMODE_LSB = 1;   // datamode 2..1
  localparam int DMODE_W   = 2;
  localparam int CTRL_LSB  = 3;   // ctrlmode 7..3
  localparam int CTRL_W    = 5;
  localparam int DST_LSB   = 8;   // dstaddr 39..8
  localparam int DATA_LSB  = 40;  // data 71..40
  localparam int SRC_LSB   = 72;  // srcaddr 103..72
  localparam int NIB_LSB   = DST_LSB + AW - 4;  // dstaddr 31..28

  // Header byte on the wire is {write, datamode, ctrlmode}
  localparam int HDR_WRITE_BIT = 7;
  localparam int HDR_DMODE_LSB = 5;  // Bits 6..5
  localparam int HDR_CTRL_LSB  = 0;  // Bits 4..0

  // Framing
  localparam int HDR_BYTES   = 13;  // Header byte, dstaddr, data, srcaddr
  localparam int BURST_BYTES = 8;   // data, srcaddr
  localparam int SHIFT_W     = (HDR_BYTES - 1) * 8;  // Payload bytes after header byte

  // Burst address step
  localparam logic [AW-1:0] BURST_STRIDE = 32'd8;

  // Local chip id, compared against dstaddr 31..20
  localparam logic [11:0] CHIP_ID = 12'h36C;

  // Region remap of the dstaddr top nibble
  localparam logic [3:0] REMAP_SEL  = 4'h3;
  localparam logic [3:0] REMAP_BASE = 4'hA;

  // Deserializer FSM
  typedef enum logic [1:0] {
    IDLE,    // Waiting for frame, next byte is header
    HEADER,  // Collecting dstaddr, data, srcaddr
    BURST    // Collecting data, srcaddr continuation groups
  } deser_state_t;

endpackage

/* source/erx_protocol.sv */
`timescale 1ns/1ns
// eLink RX protocol block
// Gates traffic by enable, rebuilds burst addresses, flags local traffic

module erx_protocol import erx_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          rx_enable,     // Receiver enable
  input  logic          rx_access,
  input  logic          rx_burst,
  input  logic [PW-1:0] rx_packet,
  output logic          erx_access,
  output logic [PW-1:0] erx_packet,
  output logic          remap_bypass   // Local address, skip remap
);

  logic [AW-1:0] dst_q;     // Last destination address
  logic [AW-1:0] dst_next;
  logic          is_local;
  logic [PW-1:0] pkt;

  // Header loads the address, bursts step from the last one
  always_comb begin
    if (rx_burst) begin
      dst_next = dst_q + BURST_STRIDE;
    end else begin
      dst_next = rx_packet[DST_LSB +: AW];
    end
  end

  assign is_local = (dst_next[AW-1 -: $bits(CHIP_ID)] == CHIP_ID);

  // Completed packet with rebuilt dstaddr
  always_comb begin
    pkt = rx_packet;
    pkt[DST_LSB +: AW] = dst_next;
  end

  // Address tracking and pulse
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dst_q <= '0;
      erx_access <= 1'b0;
      remap_bypass <= 1'b0;
    end else begin
      if (rx_access) begin
        dst_q <= dst_next;  // Tracked even when disabled
      end
      erx_access <= rx_access && rx_enable;
      remap_bypass <= rx_access && rx_enable && is_local;
    end
  end

  // Payload register
  always_ff @(posedge clk) begin
    if (rx_access) begin
      erx_packet <= pkt;
    end
  end

  // Nothing leaves while the receiver is off
  a_enable_gate: assert property (
    @(posedge clk) disable iff (!arst_n)
    erx_access |-> $past(rx_enable) && $past(rx_access)
  );

endmodule

/* source/erx_remap.sv */
`timescale 1ns/1ns
// eLink RX address remap
// Rewrites the dstaddr region nibble and registers the final transaction

module erx_remap import erx_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          erx_access,
  input  logic [PW-1:0] erx_packet,
  input  logic          remap_bypass,
  output logic          out_access,
  output logic [PW-1:0] out_packet
);

  logic [3:0]    dst_nib;
  logic          do_remap;
  logic [PW-1:0] pkt;

  assign dst_nib = erx_packet[NIB_LSB +: 4];
  assign do_remap = !remap_bypass && (dst_nib == REMAP_SEL);

  // Only the region nibble changes
  always_comb begin
    pkt = erx_packet;
    if (do_remap) begin
      pkt[NIB_LSB +: 4] = REMAP_BASE;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_access <= 1'b0;
    end else begin
      out_access <= erx_access;  // One cycle pulse
    end
  end

  always_ff @(posedge clk) begin
    if (erx_access) begin
      out_packet <= pkt;
    end
  end

endmodule

/* source/erx_top.sv */
`timescale 1ns/1ns
// eLink RX receive path
// Deserializer, protocol decode and remap in series

module erx_top import erx_pkg::*; (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          rx_enable,   // Receiver enable
  input  logic          frame,       // Frame level
  input  logic [7:0]    data,        // Link byte
  output logic          out_access,  // Transaction pulse
  output logic [PW-1:0] out_packet
);

  // Deserializer to protocol
  logic          rx_access;
  logic          rx_burst;
  logic [PW-1:0] rx_packet;

  // Protocol to remap
  logic          erx_access;
  logic [PW-1:0] erx_packet;
  logic          remap_bypass;

  erx_deser i_erx_deser (
    .clk       (clk),
    .arst_n    (arst_n),
    .frame     (frame),
    .data      (data),
    .rx_access (rx_access),
    .rx_burst  (rx_burst),
    .rx_packet (rx_packet)
  );

  erx_protocol i_erx_protocol (
    .clk          (clk),
    .arst_n       (arst_n),
    .rx_enable    (rx_enable),
    .rx_access    (rx_access),
    .rx_burst     (rx_burst),
    .rx_packet    (rx_packet),
    .erx_access   (erx_access),
    .erx_packet   (erx_packet),
    .remap_bypass (remap_bypass)
  );

  erx_remap i_erx_remap (
    .clk          (clk),
    .arst_n       (arst_n),
    .erx_access   (erx_access),
    .erx_packet   (erx_packet),
    .remap_bypass (remap_bypass),
    .out_access   (out_access),
    .out_packet   (out_packet)
  );

endmodule

/* vlog.f */
+incdir+dv
source/erx_pkg.sv
source/erx_deser.sv
source/erx_protocol.sv
source/erx_remap.sv
source/erx_top.sv
dv/erx_tb.sv
